//--- flist.f
src/rv_pkg.sv
src/rv_regfile.sv
src/rv_ramio.sv
src/rv_core.sv
src/rv_soc.sv
bench/flash_model.sv
bench/tb_rv_soc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the rv32i soc testbench with Verilator.
# Exit status is nonzero when the log reports a failure.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rv_soc \
  -Mdir obj_dir \
  -f flist.f

./obj_dir/Vtb_rv_soc | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

echo "simulation finished without failure"

//--- bench/tb_rv_soc.sv
// ==================================================================
// testbench for the rv32i soc that builds a random program, boots it
// through the flash model and checks io writes against an ISA model
// ==================================================================
`timescale 1ns/10ps
`default_nettype none

module tb_rv_soc;
  import rv_pkg::*;

  localparam int body_end     = 95;         // 31 start values plus 64 random words
  localparam int io_count     = 31;
  localparam int model_steps  = 10000;
  localparam int quiet_cycles = 200;
  localparam int max_cycles   = 2_000_000;  // boot of 256 words x ~70 plus execution

  logic   clk = 1'b0;
  logic   rst_n;
  wire    flash_clk;
  wire    flash_mosi;
  wire    flash_cs;
  wire    flash_miso;
  wire    word_t io_data;
  wire    io_valid;
  wire    led;

  word_t  mem_w [boot_bytes / 4];  // program image and later the model's memory
  word_t  regs [32];
  word_t  expected [$];            // io values from the model
  integer seed = 32'h8c9c;
  int     errors = 0;
  int     io_seen = 0;
  int     cycles = 0;
  int     n;
  int     plain_left;              // words a pending jump may still skip
  logic   timed_out = 1'b0;

  rv_soc DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .flash_miso (flash_miso),
    .flash_clk  (flash_clk),
    .flash_mosi (flash_mosi),
    .flash_cs   (flash_cs),
    .io_data    (io_data),
    .io_valid   (io_valid),
    .led        (led)
  );

  flash_model flash (
    .flash_clk  (flash_clk),
    .flash_cs   (flash_cs),
    .flash_mosi (flash_mosi),
    .flash_miso (flash_miso)
  );

  always #4 clk = ~clk;

  function automatic int rand_below(int limit);
    return int'($unsigned($random(seed)) % limit);
  endfunction

  function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                   logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  // eight words spread over the data region so loads see earlier stores
  function automatic logic [11:0] data_offset(logic [1:0] width);
    logic [11:0] off;
    off = 12'h200 + 12'(64 * rand_below(8));
    if (width == 2'd0) off[1:0] = 2'(rand_below(4));
    if (width == 2'd1) off[1] = 1'(rand_below(2));
    return off;
  endfunction

  task automatic emit(input word_t ins);
    mem_w[n] = ins;
    n++;
    if (plain_left > 0) plain_left--;
  endtask

  task automatic build_program();
    int          kind;
    int          k;
    logic [4:0]  rb;
    logic [4:0]  rd_r;
    logic [4:0]  rs1_r;
    logic [4:0]  rs2_r;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    n          = 0;
    plain_left = 0;
    for (int i = 0; i < boot_bytes / 4; i++) begin
      mem_w[i] = '0;
    end
    for (int r = 1; r < 32; r++) begin  // defined start values
      if (r % 2 == 1) begin
        emit(i_type(12'(rand_below(4096)), 5'd0, 3'd0, 5'(r), opc_op_imm));
      end else begin
        emit(u_type(20'(rand_below(1 << 20)), 5'(r), opc_lui));
      end
    end
    while (n < body_end) begin
      kind  = (plain_left > 0) ? rand_below(3) : rand_below(8);
      k     = 1 + rand_below(3);
      rb    = 5'(1 + rand_below(31));
      rd_r  = 5'(rand_below(32));
      rs1_r = 5'(rand_below(32));
      rs2_r = 5'(rand_below(32));
      f3    = 3'(rand_below(8));
      imm   = 12'(rand_below(4096));
      if (kind >= 3 && body_end - n < k + 2) kind = 0;  // no room left
      case (kind)
        0: begin
          if (f3 == 3'd1) imm[11:5] = 7'd0;
          if (f3 == 3'd5) imm[11:5] = {1'b0, imm[10], 5'd0};  // srli or srai
          emit(i_type(imm, rs1_r, f3, rd_r, opc_op_imm));
        end
        1: begin
          f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1) ? 7'h20 : 7'h00;
          emit(r_type(f7, rs2_r, rs1_r, f3, rd_r));
        end
        2: begin
          if (rand_below(2) == 1) begin
            emit(u_type(20'(rand_below(1 << 20)), rd_r, opc_lui));
          end else begin
            emit(u_type(20'(rand_below(1 << 20)), rd_r, opc_auipc));
          end
        end
        3: begin
          f3 = 3'(rand_below(5));
          if (f3 > 3'd2) f3 = f3 + 3'd1;  // lb lh lw lbu lhu
          emit(u_type(20'd0, rb, opc_lui));
          emit(i_type(data_offset(f3[1:0]), rb, f3, rd_r, opc_load));
        end
        4: begin
          f3 = 3'(rand_below(3));
          emit(u_type(20'd0, rb, opc_lui));
          emit(s_type(data_offset(f3[1:0]), rs2_r, rb, f3));
        end
        5: begin
          f3 = 3'(rand_below(6));
          if (f3 > 3'd1) f3 = f3 + 3'd2;
          emit(b_type(13'(4 * (k + 1)), rs2_r, rs1_r, f3));
          plain_left = k;
        end
        6: begin
          emit(j_type(21'(4 * (k + 1)), rd_r));
          plain_left = k;
        end
        default: begin
          emit(u_type(20'd0, rb, opc_auipc));  // rb holds this pc
          emit(i_type(12'(4 * (k + 2)), rb, 3'd0, rd_r, opc_jalr));
          plain_left = k;
        end
      endcase
    end
    for (int r = 1; r < 32; r++) begin
      emit(s_type(12'hFF0, 5'(r), 5'd0, 3'd2));  // sw xr, -16(x0)
    end
    emit(j_type(21'd0, 5'd0));
  endtask

  function automatic word_t alu_result(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t load_value(logic [2:0] f3, word_t addr);
    word_t       w;
    logic [7:0]  by;
    logic [15:0] hw;
    w  = mem_w[addr[9:2]];
    by = w[8 * addr[1:0] +: 8];
    hw = w[16 * addr[1] +: 16];
    case (f3)
      3'd0:    return {{24{by[7]}}, by};
      3'd1:    return {{16{hw[15]}}, hw};
      3'd4:    return {24'd0, by};
      3'd5:    return {16'd0, hw};
      default: return w;
    endcase
  endfunction

  task automatic store_value(input logic [2:0] f3, input word_t addr, input word_t data);
    if (addr == io_addr) begin
      expected.push_back(data);
    end else begin
      case (f3)
        3'd0:    mem_w[addr[9:2]][8 * addr[1:0] +: 8] = data[7:0];
        3'd1:    mem_w[addr[9:2]][16 * addr[1] +: 16] = data[15:0];
        default: mem_w[addr[9:2]] = data;
      endcase
    end
  endtask

  // instruction set model that runs until the final self jump
  task automatic run_model();
    word_t      pc;
    word_t      next;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      ii;
    word_t      val;
    logic [4:0] rd;
    logic [2:0] f3;
    logic       wr;
    int         steps;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    pc    = '0;
    steps = 0;
    ins   = mem_w[0];
    while (ins != j_type(21'd0, 5'd0) && steps < model_steps) begin
      f3   = ins[14:12];
      rd   = ins[11:7];
      a    = regs[ins[19:15]];
      b    = regs[ins[24:20]];
      ii   = {{20{ins[31]}}, ins[31:20]};
      val  = pc + 32'd4;
      next = pc + 32'd4;
      wr   = 1'b1;
      case (ins[6:0])
        opc_lui:    val = {ins[31:12], 12'd0};
        opc_auipc:  val = pc + {ins[31:12], 12'd0};
        opc_jal:    next = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        opc_jalr:   next = (a + ii) & ~32'd1;
        opc_op_imm: val = alu_result(f3, f3 == 3'd5 && ins[30], a, ii);
        opc_op:     val = alu_result(f3, ins[30], a, b);
        opc_load:   val = load_value(f3, a + ii);
        opc_branch: begin
          wr = 1'b0;
          if (branch_taken(f3, a, b)) begin
            next = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        opc_store: begin
          wr = 1'b0;
          store_value(f3, a + {{20{ins[31]}}, ins[31:25], ins[11:7]}, b);
        end
        default: wr = 1'b0;
      endcase
      if (wr && rd != 5'd0) regs[rd] = val;
      pc  = next;
      ins = mem_w[pc[9:2]];
      steps++;
    end
    assert (steps < model_steps)
      else begin
        $display("reference model never reached the final loop");
        errors++;
      end
  endtask

  task automatic report_and_finish();
    $display("errors: %0d checks, %0d flash protocol; io writes seen: %0d",
             errors, flash.errors, io_seen);
    if (errors == 0 && flash.errors == 0 && !timed_out) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  always @(negedge clk) begin
    if (io_valid === 1'b1) begin
      assert (io_seen < expected.size())
        else begin
          $display("io write number %0d arrived after all expected writes", io_seen);
          errors++;
        end
      if (io_seen < expected.size()) begin
        assert (io_data === expected[io_seen])
          else begin
            $display("Fail %0t: io write %0d expected %h got %h",
                     $time, io_seen, expected[io_seen], io_data);
            errors++;
          end
      end
      io_seen++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      timed_out = 1'b1;
      report_and_finish();
    end
  end

  initial begin
    rst_n = 1'b0;
    build_program();
    for (int i = 0; i < boot_bytes; i++) begin
      flash.image[i] = mem_w[i / 4][8 * (i % 4) +: 8];  // little endian words
    end
    run_model();
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    assert (flash_cs === 1'b1 && flash_clk === 1'b0 && io_valid === 1'b0 && led === 1'b1)
      else begin
        $display("Fail %0t: after reset cs=%b flash_clk=%b io_valid=%b led=%b",
                 $time, flash_cs, flash_clk, io_valid, led);
        errors++;
      end
    wait (io_seen >= io_count);
    repeat (quiet_cycles) @(posedge clk);  // catch late extra writes
    assert (expected.size() == io_count && io_seen == io_count)
      else begin
        $display("Fail %0t: %0d io writes seen, model made %0d, expected %0d",
                 $time, io_seen, expected.size(), io_count);
        errors++;
      end
    assert (led === ~io_seen[0])
      else begin
        $display("Fail %0t: led is %b after %0d io writes", $time, led, io_seen);
        errors++;
      end
    report_and_finish();
  end

endmodule

`default_nettype wire

//--- bench/flash_model.sv
// ==================================================================
// behavioral spi flash that answers one read command from address 0
// the testbench loads image before reset and reads errors at the end
// ==================================================================
`timescale 1ns/10ps
`default_nettype none

module flash_model (
  input  wire  flash_clk,
  input  wire  flash_cs,
  input  wire  flash_mosi,
  output logic flash_miso
);
  import rv_pkg::*;

  logic [7:0]  image [boot_bytes];  // filled by the testbench
  logic [31:0] header;              // command byte and 24 bit address
  logic        selected;
  int          in_bits;
  int          out_bits;
  int          errors;

  initial begin
    flash_miso = 1'b0;
    header     = '0;
    selected   = 1'b0;
    in_bits    = 0;
    out_bits   = 0;
    errors     = 0;
  end

  always @(negedge flash_cs) begin
    selected = 1'b1;
    in_bits  = 0;
    out_bits = 0;
  end

  always @(posedge flash_clk) begin
    if (selected && !flash_cs) begin
      if (in_bits < 32) begin
        header  = {header[30:0], flash_mosi};
        in_bits = in_bits + 1;
        if (in_bits == 32) begin
          assert (header == {flash_read_cmd, 24'h0})
            else begin
              $display("flash protocol error: command and address %h is not a read from 0",
                       header);
              errors++;
            end
        end
      end else begin
        out_bits = out_bits + 1;  // core took one data bit
      end
    end
  end

  // msb of each byte goes first
  always @(negedge flash_clk) begin
    if (selected && !flash_cs && in_bits == 32 && out_bits < 8 * boot_bytes) begin
      flash_miso <= #1 image[out_bits / 8][7 - out_bits % 8];
    end
  end

  always @(posedge flash_cs) begin
    if (selected) begin
      assert (out_bits == 8 * boot_bytes)
        else begin
          $display("flash protocol error: chip select released after %0d of %0d data bits",
                   out_bits, 8 * boot_bytes);
          errors++;
        end
      selected = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/rv_soc.sv
// ==================================================================
// soc top level joining the core, register file and ramio
// flash pins go to an external spi flash, io and led report results
// ==================================================================
`timescale 1ns/10ps
`default_nettype none

module rv_soc (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                flash_miso,
  output wire                flash_clk,
  output wire                flash_mosi,
  output wire                flash_cs,
  output wire rv_pkg::word_t io_data,
  output wire                io_valid,
  output wire                led
);
  import rv_pkg::*;

  // ramio handshake
  wire              ramio_enable;
  wire write_type_t ramio_write_type;
  wire read_type_t  ramio_read_type;
  wire word_t       ramio_address;
  wire word_t       ramio_data_in;
  wire word_t       ramio_data_out;
  wire              ramio_data_out_ready;
  wire              ramio_busy;

  // register file ports
  wire reg_addr_t   rs1;
  wire reg_addr_t   rs2;
  wire reg_addr_t   rd;
  wire word_t       rs1_dat;
  wire word_t       rs2_dat;
  wire word_t       rd_wd;
  wire              rd_we;

  rv_core u_core (.*);

  rv_regfile u_regfile (.*);

  rv_ramio u_ramio (.*);

endmodule

`default_nettype wire

//--- src/rv_core.sv
// ==================================================================
// rv32i multicycle core with spi flash boot loader
// copies the flash image into ram over ramio, then runs it from 0
// ==================================================================
`timescale 1ns/10ps
`default_nettype none

module rv_core (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire rv_pkg::word_t    ramio_data_out,
  input  wire                   ramio_data_out_ready,
  input  wire                   ramio_busy,
  input  wire                   flash_miso,
  input  wire rv_pkg::word_t    rs1_dat,
  input  wire rv_pkg::word_t    rs2_dat,
  output logic                  ramio_enable,
  output rv_pkg::write_type_t   ramio_write_type,
  output rv_pkg::read_type_t    ramio_read_type,
  output rv_pkg::word_t         ramio_address,
  output rv_pkg::word_t         ramio_data_in,
  output logic                  flash_clk,
  output logic                  flash_mosi,
  output logic                  flash_cs,
  output rv_pkg::reg_addr_t     rs1,
  output rv_pkg::reg_addr_t     rs2,
  output rv_pkg::reg_addr_t     rd,
  output rv_pkg::word_t         rd_wd,
  output logic                  rd_we
);
  import rv_pkg::*;

  core_state_t state;
  core_state_t return_state;  // where boot_send goes when done

  logic [boot_wait_w-1:0] wait_cnt;
  logic [23:0] flash_shift;   // msb goes out first
  logic [4:0]  bit_cnt;
  logic        flash_phase;   // set during the high half of an spi bit
  logic [7:0]  byte_sr;
  word_t       word_sr;       // bytes packed little endian
  word_t       boot_addr_next;

  word_t pc;
  word_t ir;
  word_t alu_b;
  word_t alu_res;
  word_t next_pc;
  logic  take_branch;

  wire logic [6:0] opcode    = ir[6:0];
  wire logic [2:0] funct3    = ir[14:12];
  wire word_t      imm_i     = {{20{ir[31]}}, ir[31:20]};
  wire word_t      imm_s     = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  wire word_t      imm_b     = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
  wire word_t      imm_j     = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
  wire word_t      imm_u     = {ir[31:12], 12'b0};
  wire logic [7:0] byte_next = {byte_sr[6:0], flash_miso};

  always_comb begin
    alu_b = (opcode == opc_op) ? rs2_dat : imm_i;  // imm_i[4:0] is the shamt
    case (funct3)
      3'b000:  alu_res = (opcode == opc_op && ir[30]) ? rs1_dat - alu_b : rs1_dat + alu_b;
      3'b001:  alu_res = rs1_dat << alu_b[4:0];
      3'b010:  alu_res = {31'b0, $signed(rs1_dat) < $signed(alu_b)};
      3'b011:  alu_res = {31'b0, rs1_dat < alu_b};
      3'b100:  alu_res = rs1_dat ^ alu_b;
      3'b101:  alu_res = ir[30] ? word_t'($signed(rs1_dat) >>> alu_b[4:0])
                                : rs1_dat >> alu_b[4:0];
      3'b110:  alu_res = rs1_dat | alu_b;
      default: alu_res = rs1_dat & alu_b;
    endcase

    case (funct3)
      3'b000:  take_branch = rs1_dat == rs2_dat;
      3'b001:  take_branch = rs1_dat != rs2_dat;
      3'b100:  take_branch = $signed(rs1_dat) < $signed(rs2_dat);
      3'b101:  take_branch = $signed(rs1_dat) >= $signed(rs2_dat);
      3'b110:  take_branch = rs1_dat < rs2_dat;
      3'b111:  take_branch = rs1_dat >= rs2_dat;
      default: take_branch = 1'b0;
    endcase

    case (opcode)
      opc_jal:    next_pc = pc + imm_j;
      opc_jalr:   next_pc = (rs1_dat + imm_i) & ~32'd1;
      opc_branch: next_pc = take_branch ? pc + imm_b : pc + 32'd4;
      default:    next_pc = pc + 32'd4;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state            <= boot_wait;
      return_state     <= boot_wait;
      wait_cnt         <= '0;
      flash_shift      <= '0;
      bit_cnt          <= '0;
      flash_phase      <= 1'b0;
      byte_sr          <= '0;
      word_sr          <= '0;
      boot_addr_next   <= '0;
      pc               <= '0;
      ir               <= '0;
      rs1              <= '0;
      rs2              <= '0;
      rd               <= '0;
      rd_wd            <= '0;
      rd_we            <= 1'b0;
      ramio_enable     <= 1'b0;
      ramio_write_type <= wt_none;
      ramio_read_type  <= rt_none;
      ramio_address    <= '0;
      ramio_data_in    <= '0;
      flash_clk        <= 1'b0;
      flash_mosi       <= 1'b0;
      flash_cs         <= 1'b1;
    end else begin
      case (state)
        boot_wait: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == boot_wait_w'(boot_wait_cycles - 1)) begin
            flash_cs <= 1'b0;  // select flash for the whole image
            state    <= boot_cmd;
          end
        end
        boot_cmd: begin
          flash_shift  <= {flash_read_cmd, 16'h0};
          bit_cnt      <= 5'd8;
          return_state <= boot_addr;
          state        <= boot_send;
        end
        boot_addr: begin
          flash_shift  <= '0;  // start address 0
          bit_cnt      <= 5'd24;
          return_state <= boot_read;
          state        <= boot_send;
        end
        boot_send: begin
          flash_phase <= ~flash_phase;
          if (!flash_phase) begin
            flash_clk   <= 1'b0;
            flash_mosi  <= flash_shift[23];
            flash_shift <= {flash_shift[22:0], 1'b0};
            bit_cnt     <= bit_cnt - 1'b1;
          end else begin
            flash_clk <= 1'b1;  // flash samples mosi here
            if (bit_cnt == '0) begin
              state <= return_state;
            end
          end
        end
        boot_read: begin
          flash_phase <= ~flash_phase;
          if (!flash_phase) begin
            flash_clk <= 1'b0;
          end else begin
            flash_clk <= 1'b1;
            byte_sr   <= byte_next;
            bit_cnt   <= bit_cnt + 1'b1;  // wraps after 32 bits
            if (bit_cnt[2:0] == 3'd7) begin
              word_sr <= {byte_next, word_sr[31:8]};
            end
            if (bit_cnt == 5'd31) begin
              state <= boot_start_write;
            end
          end
        end
        boot_start_write: begin
          ramio_enable     <= 1'b1;
          ramio_write_type <= wt_word;
          ramio_read_type  <= rt_none;
          ramio_address    <= boot_addr_next;
          ramio_data_in    <= word_sr;
          boot_addr_next   <= boot_addr_next + 32'd4;
          state            <= boot_write;
        end
        boot_write: begin
          if (ramio_enable) begin
            ramio_enable <= 1'b0;  // ramio takes the request this cycle
          end else if (!ramio_busy) begin
            ramio_write_type <= wt_none;
            if (boot_addr_next < word_t'(boot_bytes)) begin
              state <= boot_read;
            end else begin
              flash_cs        <= 1'b1;
              pc              <= '0;
              ramio_enable    <= 1'b1;
              ramio_read_type <= rt_word;
              ramio_address   <= '0;
              state           <= cpu_fetch;
            end
          end
        end
        cpu_fetch: begin
          rd_we <= 1'b0;  // previous write back lands this cycle
          if (ramio_data_out_ready) begin
            ramio_enable <= 1'b0;
            ir           <= ramio_data_out;
            rs1          <= ramio_data_out[19:15];
            rs2          <= ramio_data_out[24:20];
            rd           <= ramio_data_out[11:7];
            state        <= cpu_execute;
          end
        end
        cpu_execute: begin
          pc               <= next_pc;
          ramio_enable     <= 1'b1;
          ramio_address    <= next_pc;  // next fetch unless memory access
          ramio_read_type  <= rt_word;
          ramio_write_type <= wt_none;
          state            <= cpu_fetch;
          case (opcode)
            opc_lui: begin
              rd_wd <= imm_u;
              rd_we <= 1'b1;
            end
            opc_auipc: begin
              rd_wd <= pc + imm_u;
              rd_we <= 1'b1;
            end
            opc_jal, opc_jalr: begin
              rd_wd <= pc + 32'd4;
              rd_we <= 1'b1;
            end
            opc_op_imm, opc_op: begin
              rd_wd <= alu_res;
              rd_we <= 1'b1;
            end
            opc_load: begin
              ramio_address   <= rs1_dat + imm_i;
              ramio_read_type <= {~funct3[2], funct3[1:0] + 2'd1};
              state           <= cpu_load;
            end
            opc_store: begin
              ramio_address    <= rs1_dat + imm_s;
              ramio_read_type  <= rt_none;
              ramio_write_type <= funct3[1:0] + 2'd1;
              ramio_data_in    <= rs2_dat;
              state            <= cpu_store;
            end
            default: ;
          endcase
        end
        cpu_store: begin
          if (ramio_enable) begin
            ramio_enable <= 1'b0;
          end else if (!ramio_busy) begin
            ramio_enable     <= 1'b1;
            ramio_write_type <= wt_none;
            ramio_read_type  <= rt_word;
            ramio_address    <= pc;
            state            <= cpu_fetch;
          end
        end
        cpu_load: begin
          if (ramio_data_out_ready) begin
            ramio_enable <= 1'b0;
            rd_wd        <= ramio_data_out;
            rd_we        <= 1'b1;
            state        <= cpu_load_done;
          end
        end
        cpu_load_done: begin
          rd_we           <= 1'b0;
          ramio_enable    <= 1'b1;
          ramio_read_type <= rt_word;
          ramio_address   <= pc;
          state           <= cpu_fetch;
        end
        default: state <= boot_wait;
      endcase
    end
  end

  // one access kind per ramio request
  a_one_access_type: assert property (@(posedge clk) disable iff (!rst_n)
    ramio_enable |-> (ramio_write_type == wt_none || ramio_read_type == rt_none));

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {[boot_wait:cpu_load_done]});

endmodule

`default_nettype wire

//--- src/rv_ramio.sv
// ==================================================================
// on-chip word ram behind the ramio handshake, with byte lanes,
// load extension and the memory mapped output register at io_addr
// ==================================================================
`timescale 1ns/10ps
`default_nettype none

module rv_ramio (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     ramio_enable,
  input  wire rv_pkg::write_type_t ramio_write_type,
  input  wire rv_pkg::read_type_t ramio_read_type,
  input  wire rv_pkg::word_t      ramio_address,
  input  wire rv_pkg::word_t      ramio_data_in,
  output rv_pkg::word_t           ramio_data_out,
  output logic                    ramio_data_out_ready,
  output logic                    ramio_busy,
  output rv_pkg::word_t           io_data,
  output logic                    io_valid,
  output logic                    led
);
  import rv_pkg::*;

  localparam int unsigned idx_w = $clog2(ram_words);

  word_t      mem [ram_words];
  logic [3:0] be;       // byte lane enables
  word_t      wdata;    // store data replicated on all lanes
  word_t      raw_q;
  logic [1:0] lane_q;
  read_type_t type_q;
  logic       io_q;
  word_t      ext;

  wire logic [idx_w-1:0] idx      = ramio_address[idx_w+1:2];
  wire logic             is_io    = ramio_address == io_addr;
  wire logic             rd_req   = ramio_enable && ramio_read_type[1:0] != 2'b00;
  wire logic             wr_req   = ramio_enable && ramio_write_type != wt_none;
  wire logic             io_store = wr_req && is_io && ramio_write_type == wt_word;
  wire logic [7:0]       rbyte    = raw_q[8*lane_q +: 8];
  wire logic [15:0]      rhalf    = raw_q[16*lane_q[1] +: 16];

  always_comb begin
    case (ramio_write_type)
      wt_byte: begin
        be    = 4'b0001 << ramio_address[1:0];
        wdata = {4{ramio_data_in[7:0]}};
      end
      wt_half: begin
        be    = ramio_address[1] ? 4'b1100 : 4'b0011;
        wdata = {2{ramio_data_in[15:0]}};
      end
      default: begin
        be    = 4'b1111;
        wdata = ramio_data_in;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_req && !is_io) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          mem[idx][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
    if (rd_req) begin
      raw_q  <= mem[idx];
      lane_q <= ramio_address[1:0];
      type_q <= ramio_read_type;
      io_q   <= is_io;
    end
    if (io_store) begin
      io_data <= ramio_data_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ramio_data_out_ready <= 1'b0;
      ramio_busy           <= 1'b0;
      io_valid             <= 1'b0;
      led                  <= 1'b1;
    end else begin
      ramio_data_out_ready <= rd_req;  // data follows one cycle later
      ramio_busy           <= wr_req;
      io_valid             <= io_store;
      if (io_store) begin
        led <= ~led;
      end
    end
  end

  always_comb begin
    case (type_q[1:0])
      2'b01:   ext = {{24{type_q[2] & rbyte[7]}}, rbyte};
      2'b10:   ext = {{16{type_q[2] & rhalf[15]}}, rhalf};
      default: ext = raw_q;
    endcase
    ramio_data_out = io_q ? '0 : ext;  // output register reads back zero
  end

  a_ready_busy_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(ramio_data_out_ready && ramio_busy));

endmodule

`default_nettype wire

//--- src/rv_regfile.sv
// ==================================================================
// rv32i register file with two combinational reads and one clocked write
// ==================================================================
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
  input  wire                   clk,
  input  wire rv_pkg::reg_addr_t rs1,
  input  wire rv_pkg::reg_addr_t rs2,
  input  wire rv_pkg::reg_addr_t rd,
  input  wire rv_pkg::word_t    rd_wd,
  input  wire                   rd_we,
  output rv_pkg::word_t         rs1_dat,
  output rv_pkg::word_t         rs2_dat
);
  import rv_pkg::*;

  word_t regs [32];  // entry 0 is never written

  always_ff @(posedge clk) begin
    if (rd_we && rd != '0) begin
      regs[rd] <= rd_wd;
    end
  end

  assign rs1_dat = (rs1 == '0) ? '0 : regs[rs1];  // x0 reads zero
  assign rs2_dat = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- src/rv_pkg.sv
// ==================================================================
// shared widths, rv32i opcodes, ramio access codes and core states
// imported by the core, register file, ramio and soc top level
// ==================================================================
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;        // data and byte address
  typedef logic [4:0]  reg_addr_t;    // x0..x31
  typedef logic [1:0]  write_type_t;  // store width code
  typedef logic [2:0]  read_type_t;   // bit 2 requests sign extension

  typedef enum logic [3:0] {
    boot_wait,
    boot_cmd,
    boot_send,
    boot_addr,
    boot_read,
    boot_start_write,
    boot_write,
    cpu_fetch,
    cpu_execute,
    cpu_store,
    cpu_load,
    cpu_load_done
  } core_state_t;

  // rv32i major opcodes
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;

  // ramio access codes
  localparam write_type_t wt_none = 2'b00;
  localparam write_type_t wt_byte = 2'b01;
  localparam write_type_t wt_half = 2'b10;
  localparam write_type_t wt_word = 2'b11;
  localparam read_type_t  rt_none = 3'b000;
  localparam read_type_t  rt_word = 3'b111;  // used for instruction fetch

  // boot sequence
  localparam int unsigned boot_wait_cycles = 16;
  localparam int unsigned boot_wait_w      = $clog2(boot_wait_cycles + 1);
  localparam int unsigned boot_bytes       = 1024;  // image copied from flash
  localparam logic [7:0]  flash_read_cmd   = 8'h03;

  // memory map
  localparam int unsigned ram_words = 1024;
  localparam word_t       io_addr   = 32'hFFFF_FFF0;  // output register

endpackage

`default_nettype wire
